//--- Makefile
TOOL       := verilator
TOP        := tb_cnn_accel
RTL_TOP    := cnn_accel_top
FILELIST   := files.f
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- files.f
logic/cnn_pkg.sv
logic/image_buffer.sv
logic/reg_bank.sv
logic/frame_sequencer.sv
logic/conv_kernel.sv
logic/cnn_accel_top.sv
tests/tb_cnn_accel.sv

//--- logic/cnn_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_accel_top import cnn_pkg::*; (
	input  wire logic                      clk,
	input  wire logic                      rstn,
	input  wire logic                      req_i,
	input  wire logic                      we_i,
	input  wire logic [REG_AW-1:0]         addr_i,
	input  wire logic [DATA_W-1:0]         wdata_i,
	output      logic                      ack_o,
	output      logic [DATA_W-1:0]         rdata_o,
	output      logic [N_KERN*PIX_W-1:0]   out_pixel_o,
	output      logic                      out_valid_o
);

	logic [DIM_W-1:0]                        width;
	logic [DIM_W-1:0]                        height;
	act_e                                    act_type;
	logic [4:0]                              bias_shift;
	logic [2:0]                              act_shift;
	logic [N_KERN-1:0][BIAS_W-1:0]           bias;
	logic [N_TAPS-1:0][N_KERN-1:0][PIX_W-1:0] weight;
	logic                                    start;
	logic                                    img_we;
	logic [IMG_AW-1:0]                       img_waddr;
	logic [PIX_W-1:0]                        img_wdata;
	logic [IMG_AW-1:0]                       raddr;
	logic [PIX_W-1:0]                        pix;
	logic                                    pad;
	logic                                    tap_first;
	logic                                    tap_last;
	logic                                    layer_done;
	logic [N_KERN-1:0][N_TAPS-1:0][PIX_W-1:0] kern_w;   // Weights regrouped per kernel
	logic [N_KERN-1:0][PIX_W-1:0]            kern_act;
	logic [N_KERN-1:0]                       kern_vld;

	reg_bank i_reg_bank (
		.clk          (clk),
		.rstn         (rstn),
		.req_i        (req_i),
		.we_i         (we_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.layer_done_i (layer_done),
		.ack_o        (ack_o),
		.rdata_o      (rdata_o),
		.width_o      (width),
		.height_o     (height),
		.act_type_o   (act_type),
		.bias_shift_o (bias_shift),
		.act_shift_o  (act_shift),
		.bias_o       (bias),
		.weight_o     (weight),
		.start_o      (start),
		.img_we_o     (img_we),
		.img_waddr_o  (img_waddr),
		.img_wdata_o  (img_wdata)
	);

	image_buffer i_image_buffer (
		.clk     (clk),
		.we_i    (img_we),
		.waddr_i (img_waddr),
		.wdata_i (img_wdata),
		.raddr_i (raddr),
		.rdata_o (pix)
	);

	frame_sequencer i_frame_sequencer (
		.clk          (clk),
		.rstn         (rstn),
		.start_i      (start),
		.width_i      (width),
		.height_i     (height),
		.raddr_o      (raddr),
		.pad_o        (pad),
		.tap_first_o  (tap_first),
		.tap_last_o   (tap_last),
		.layer_done_o (layer_done)
	);

	// --------------------------------------------------
	// Output channels
	// --------------------------------------------------
	for (genvar k = 0; k < N_KERN; k++) begin : g_kern
		for (genvar t = 0; t < N_TAPS; t++) begin : g_tap
			assign kern_w[k][t] = weight[t][k];  // Byte k of tap word t
		end

		conv_kernel i_conv_kernel (
			.clk          (clk),
			.rstn         (rstn),
			.pix_i        (pix),
			.pad_i        (pad),
			.tap_first_i  (tap_first),
			.tap_last_i   (tap_last),
			.weight_i     (kern_w[k]),
			.bias_i       (bias[k]),
			.bias_shift_i (bias_shift),
			.act_shift_i  (act_shift),
			.act_type_i   (act_type),
			.act_o        (kern_act[k]),
			.vld_o        (kern_vld[k])
		);
	end

	// Channel 0 in the low byte
	assign out_pixel_o = kern_act;
	assign out_valid_o = kern_vld[0];

endmodule

`default_nettype wire

//--- logic/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	// --------------------------------------------------
	// Sizes
	// --------------------------------------------------
	localparam int MAX_DIM   = 16;   // Largest width or height
	localparam int DIM_W     = 5;
	localparam int IMG_DEPTH = 256;  // MAX_DIM squared
	localparam int IMG_AW    = 8;
	localparam int PIX_W     = 8;
	localparam int N_KERN    = 4;
	localparam int N_TAPS    = 9;    // 3x3 window
	localparam int TAP_W     = 4;
	localparam int BIAS_W    = 16;
	localparam int ACC_W     = 32;
	localparam int REG_AW    = 6;
	localparam int DATA_W    = 32;

	// --------------------------------------------------
	// Register map, word addresses
	// --------------------------------------------------
	localparam logic [REG_AW-1:0] REG_DIM         = 6'd0;  // Width 4:0, height 20:16
	localparam logic [REG_AW-1:0] REG_LAYER_CFG   = 6'd1;  // Act 3, bias shift 12:8, act shift 15:13
	localparam logic [REG_AW-1:0] REG_START       = 6'd2;
	localparam logic [REG_AW-1:0] REG_DONE        = 6'd3;
	localparam logic [REG_AW-1:0] REG_IMG_INDEX   = 6'd4;
	localparam logic [REG_AW-1:0] REG_IMG_DATA    = 6'd5;  // Index auto-increments
	localparam logic [REG_AW-1:0] REG_BIAS_BASE   = 6'd8;  // One per kernel
	localparam logic [REG_AW-1:0] REG_WEIGHT_BASE = 6'd16; // One per tap, byte k for kernel k

	// Shift defaults after reset
	localparam logic [4:0] RESET_BIAS_SHIFT = 5'd9;
	localparam logic [2:0] RESET_ACT_SHIFT  = 3'd7;

	// Activation select
	typedef enum logic {
		ACT_RELU   = 1'b0,  // Clamp to 0..255
		ACT_LINEAR = 1'b1   // Clamp to -128..127
	} act_e;

	// Layer sequencer
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_DRAIN
	} seq_state_e;

	// Four-phase host handshake
	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_ACK,
		BUS_WAIT_DROP
	} bus_state_e;

endpackage

`default_nettype wire

//--- logic/conv_kernel.sv
`timescale 1ns/1ps
`default_nettype none

module conv_kernel import cnn_pkg::*; (
	input  wire logic                         clk,
	input  wire logic                         rstn,
	input  wire logic [PIX_W-1:0]             pix_i,
	input  wire logic                         pad_i,
	input  wire logic                         tap_first_i,
	input  wire logic                         tap_last_i,
	input  wire logic [N_TAPS-1:0][PIX_W-1:0] weight_i,
	input  wire logic [BIAS_W-1:0]            bias_i,
	input  wire logic [4:0]                   bias_shift_i,
	input  wire logic [2:0]                   act_shift_i,
	input  wire act_e                         act_type_i,
	output      logic [PIX_W-1:0]             act_o,
	output      logic                         vld_o
);

	logic        [TAP_W-1:0]   tap_cnt_q;  // Next tap, zero when idle
	logic        [TAP_W-1:0]   tap_sel;
	logic signed [PIX_W:0]     pix_s;      // Unsigned pixel, one sign bit added
	logic signed [2*PIX_W:0]   prod;
	logic signed [ACC_W-1:0]   acc_q;
	logic signed [ACC_W-1:0]   acc_nxt;
	logic signed [ACC_W-1:0]   bias_ext;
	logic signed [ACC_W-1:0]   total;
	logic signed [ACC_W-1:0]   scaled;
	logic        [PIX_W-1:0]   act_nxt;

	// --------------------------------------------------
	// MAC
	// --------------------------------------------------
	always_comb begin
		tap_sel = tap_first_i ? '0 : tap_cnt_q;
		pix_s   = pad_i ? '0 : $signed({1'b0, pix_i});
		prod    = pix_s * $signed(weight_i[tap_sel]);
		acc_nxt = (tap_first_i ? '0 : acc_q) + ACC_W'(prod);
	end

	// Bias, rescale and clamp for the last tap
	always_comb begin
		bias_ext = ACC_W'($signed(bias_i)) <<< bias_shift_i;
		total    = acc_nxt + bias_ext;
		scaled   = total >>> act_shift_i;
		if (act_type_i == ACT_RELU) begin
			if (scaled < 0)
				act_nxt = '0;
			else if (scaled > 255)
				act_nxt = 8'hff;
			else
				act_nxt = scaled[PIX_W-1:0];
		end else begin
			if (scaled < -128)
				act_nxt = 8'h80;
			else if (scaled > 127)
				act_nxt = 8'h7f;
			else
				act_nxt = scaled[PIX_W-1:0];  // Two's complement
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			tap_cnt_q <= '0;
			vld_o     <= 1'b0;
		end else begin
			vld_o <= tap_last_i;
			if (tap_first_i)
				tap_cnt_q <= TAP_W'(1);
			else if (tap_last_i)
				tap_cnt_q <= '0;
			else if (tap_cnt_q != '0)
				tap_cnt_q <= tap_cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		acc_q <= acc_nxt;
		if (tap_last_i) begin
			act_o <= act_nxt;
		end
	end

endmodule

`default_nettype wire

//--- logic/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer import cnn_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rstn,
	input  wire logic              start_i,
	input  wire logic [DIM_W-1:0]  width_i,
	input  wire logic [DIM_W-1:0]  height_i,
	output      logic [IMG_AW-1:0] raddr_o,
	output      logic              pad_o,
	output      logic              tap_first_o,
	output      logic              tap_last_o,
	output      logic              layer_done_o
);

	seq_state_e       state_q;
	logic [DIM_W-1:0] row_q;
	logic [DIM_W-1:0] col_q;
	logic [TAP_W-1:0] tap_q;
	logic [1:0]       tr;     // Window row 0..2
	logic [1:0]       tc;     // Window column 0..2
	logic [DIM_W:0]   nr_p1;  // Neighbour row plus one
	logic [DIM_W:0]   nc_p1;
	logic             pad;
	logic             run;

	assign run = (state_q == SEQ_RUN);

	// --------------------------------------------------
	// Neighbour address for the current tap
	// --------------------------------------------------
	always_comb begin
		tr    = (tap_q >= TAP_W'(6)) ? 2'd2 : (tap_q >= TAP_W'(3)) ? 2'd1 : 2'd0;
		tc    = 2'(tap_q - TAP_W'(3) * TAP_W'(tr));
		nr_p1 = {1'b0, row_q} + {{(DIM_W-1){1'b0}}, tr};
		nc_p1 = {1'b0, col_q} + {{(DIM_W-1){1'b0}}, tc};
		// Outside the image on any side
		pad   = (nr_p1 == '0) || (nr_p1 > {1'b0, height_i}) ||
		        (nc_p1 == '0) || (nc_p1 > {1'b0, width_i});
	end

	// Address is junk on padded taps, the kernel zeroes those
	assign raddr_o = IMG_AW'(nr_p1 - 1'b1) * IMG_AW'(width_i) + IMG_AW'(nc_p1 - 1'b1);

	// --------------------------------------------------
	// Layer FSM and counters
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q      <= SEQ_IDLE;
			row_q        <= '0;
			col_q        <= '0;
			tap_q        <= '0;
			layer_done_o <= 1'b0;
		end else begin
			case (state_q)
				SEQ_IDLE: begin
					if (start_i) begin
						state_q      <= SEQ_RUN;
						row_q        <= '0;
						col_q        <= '0;
						tap_q        <= '0;
						layer_done_o <= 1'b0;
					end
				end
				SEQ_RUN: begin
					if (tap_q == TAP_W'(N_TAPS-1)) begin
						tap_q <= '0;
						if (col_q == width_i - 1'b1) begin
							col_q <= '0;
							if (row_q == height_i - 1'b1) begin
								row_q   <= '0;
								state_q <= SEQ_DRAIN;  // Last tap of last pixel issued
							end else begin
								row_q <= row_q + 1'b1;
							end
						end else begin
							col_q <= col_q + 1'b1;
						end
					end else begin
						tap_q <= tap_q + 1'b1;
					end
				end
				SEQ_DRAIN: begin
					// Final output leaves the kernels on this edge
					state_q      <= SEQ_IDLE;
					layer_done_o <= 1'b1;
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

	// Strobes follow the pixel through the buffer read
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			pad_o       <= 1'b0;
			tap_first_o <= 1'b0;
			tap_last_o  <= 1'b0;
		end else begin
			pad_o       <= run && pad;
			tap_first_o <= run && (tap_q == '0);
			tap_last_o  <= run && (tap_q == TAP_W'(N_TAPS-1));
		end
	end

	a_tap_range: assert property (@(posedge clk) disable iff (!rstn)
		tap_q < TAP_W'(N_TAPS));

endmodule

`default_nettype wire

//--- logic/image_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module image_buffer import cnn_pkg::*; (
	input  wire logic              clk,
	input  wire logic              we_i,
	input  wire logic [IMG_AW-1:0] waddr_i,
	input  wire logic [PIX_W-1:0]  wdata_i,
	input  wire logic [IMG_AW-1:0] raddr_i,
	output      logic [PIX_W-1:0]  rdata_o
);

	// Row-major image, index = row * width + col
	logic [PIX_W-1:0] mem [IMG_DEPTH];

	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	// Registered read, one cycle behind the address
	always_ff @(posedge clk) begin
		rdata_o <= mem[raddr_i];
	end

endmodule

`default_nettype wire

//--- logic/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank import cnn_pkg::*; (
	input  wire logic                                    clk,
	input  wire logic                                    rstn,
	input  wire logic                                    req_i,
	input  wire logic                                    we_i,
	input  wire logic [REG_AW-1:0]                       addr_i,
	input  wire logic [DATA_W-1:0]                       wdata_i,
	input  wire logic                                    layer_done_i,
	output      logic                                    ack_o,
	output      logic [DATA_W-1:0]                       rdata_o,
	output      logic [DIM_W-1:0]                        width_o,
	output      logic [DIM_W-1:0]                        height_o,
	output      act_e                                    act_type_o,
	output      logic [4:0]                              bias_shift_o,
	output      logic [2:0]                              act_shift_o,
	output      logic [N_KERN-1:0][BIAS_W-1:0]           bias_o,
	output      logic [N_TAPS-1:0][N_KERN-1:0][PIX_W-1:0] weight_o,
	output      logic                                    start_o,
	output      logic                                    img_we_o,
	output      logic [IMG_AW-1:0]                       img_waddr_o,
	output      logic [PIX_W-1:0]                        img_wdata_o
);

	bus_state_e        bus_state_q;
	logic              access;   // One cycle per req pulse
	logic              wr;
	logic [IMG_AW:0]   img_idx_q; // One extra bit to catch overrun
	logic [DATA_W-1:0] rd_mux;

	assign access = (bus_state_q == BUS_IDLE) && req_i;
	assign wr     = access && we_i;
	assign ack_o  = (bus_state_q != BUS_IDLE);

	// --------------------------------------------------
	// Handshake
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			bus_state_q <= BUS_IDLE;
		end else begin
			case (bus_state_q)
				BUS_IDLE:      if (req_i) bus_state_q <= BUS_ACK;
				BUS_ACK:       bus_state_q <= req_i ? BUS_WAIT_DROP : BUS_IDLE;
				BUS_WAIT_DROP: if (!req_i) bus_state_q <= BUS_IDLE;
				default:       bus_state_q <= BUS_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// Configuration registers
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			width_o      <= DIM_W'(MAX_DIM);
			height_o     <= DIM_W'(MAX_DIM);
			act_type_o   <= ACT_RELU;
			bias_shift_o <= RESET_BIAS_SHIFT;
			act_shift_o  <= RESET_ACT_SHIFT;
			img_idx_q    <= '0;
		end else if (wr) begin
			case (addr_i)
				REG_DIM: begin
					width_o  <= wdata_i[DIM_W-1:0];
					height_o <= wdata_i[16+DIM_W-1:16];
				end
				REG_LAYER_CFG: begin
					act_type_o   <= act_e'(wdata_i[3]);
					bias_shift_o <= wdata_i[12:8];
					act_shift_o  <= wdata_i[15:13];
				end
				REG_IMG_INDEX: img_idx_q <= wdata_i[IMG_AW:0];
				REG_IMG_DATA:  img_idx_q <= img_idx_q + 1'b1;
				default: ;
			endcase
		end
	end

	// Weights and biases, written by the host before a run
	always_ff @(posedge clk) begin
		if (wr) begin
			for (int k = 0; k < N_KERN; k++) begin
				if (addr_i == REG_BIAS_BASE + REG_AW'(k)) bias_o[k] <= wdata_i[BIAS_W-1:0];
			end
			for (int t = 0; t < N_TAPS; t++) begin
				if (addr_i == REG_WEIGHT_BASE + REG_AW'(t)) weight_o[t] <= wdata_i;
			end
		end
	end

	// Write strobes
	assign start_o     = wr && (addr_i == REG_START) && wdata_i[0];
	assign img_we_o    = wr && (addr_i == REG_IMG_DATA);
	assign img_waddr_o = img_idx_q[IMG_AW-1:0];
	assign img_wdata_o = wdata_i[PIX_W-1:0];

	// --------------------------------------------------
	// Read path
	// --------------------------------------------------
	always_comb begin
		rd_mux = '0;
		case (addr_i)
			REG_DIM:       rd_mux = {{(16-DIM_W){1'b0}}, height_o, {(16-DIM_W){1'b0}}, width_o};
			REG_LAYER_CFG: rd_mux = {16'b0, act_shift_o, bias_shift_o, 4'b0, act_type_o, 3'b0};
			REG_DONE:      rd_mux = {{(DATA_W-1){1'b0}}, layer_done_i};
			REG_IMG_INDEX: rd_mux = DATA_W'(img_idx_q);
			default: ;
		endcase
		for (int k = 0; k < N_KERN; k++) begin
			if (addr_i == REG_BIAS_BASE + REG_AW'(k)) rd_mux = DATA_W'(bias_o[k]);
		end
		for (int t = 0; t < N_TAPS; t++) begin
			if (addr_i == REG_WEIGHT_BASE + REG_AW'(t)) rd_mux = weight_o[t];
		end
	end

	// Held for as long as ack is up
	always_ff @(posedge clk) begin
		if (access && !we_i) begin
			rdata_o <= rd_mux;
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
		$rose(ack_o) |-> $past(req_i));

	// Host must not load past the end of the pixel memory
	a_img_idx_range: assert property (@(posedge clk) disable iff (!rstn)
		img_we_o |-> (img_idx_q < (IMG_AW+1)'(IMG_DEPTH)));

endmodule

`default_nettype wire

//--- tests/cnn_testdata.hex
// One 32-bit word per entry, in order: DIM, LAYER_CFG relu, LAYER_CFG linear,
// bias 0..3, weight tap 0..8, pixels row-major, expected relu words, expected linear words
// Image 5 wide, 4 high
00040005
// ReLU, bias shift 1, act shift 1
00002100
// Linear, no shifts
00000008
// Biases 5, -20, 40, -3
00000005 0000FFEC 00000028 0000FFFD
// Weights, byte k for kernel k
// k0 centre only, k1 all 5, k2 all -2, k3 right minus left
00FE0500 00FE0500 00FE0500
FFFE0500 00FE0501 01FE0500
00FE0500 00FE0500 00FE0500
// Pixels, one image row per line
00000001 00000002 00000003 00000004 00000005
00000006 00000007 00000008 00000009 0000000A
0000000B 0000000C 0000000D 0000000E 0000000F
00000010 00000011 00000012 00000013 00000014
// Expected ReLU output, kernel 0 in the low byte
00181405 000D2F06 00073E06 00014D07 000C3207
00014D08 00008908 0000A009 0000B609 00007A0A
0300980A 0000FA0B 0000FF0B 0000FF0C 0000C50C
0500780D 0000C50D 0000D40E 0000E30E 0000960F
// Expected linear output
FF083C06 FFF27307 FFE67F08 FFDA7F09 F9F0780A
04DA7F0B FFAA7F0C FF987F0D FF867F0E F4B67F0F
099E7F10 FF807F11 FF807F12 FF807F13 EF807F14
0EB87F15 FF807F16 FF807F17 FF807F18 EAA07F19

//--- tests/tb_cnn_accel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_accel import cnn_pkg::*; ();

	logic                    clk = 1'b0;
	logic                    rstn;
	logic                    req;
	logic                    we;
	logic [REG_AW-1:0]       addr;
	logic [DATA_W-1:0]       wdata;
	logic                    ack;
	logic [DATA_W-1:0]       rdata;
	logic [N_KERN*PIX_W-1:0] out_pixel;
	logic                    out_valid;

	logic [31:0] tdata [76];       // Word layout is described in the hex file
	int          n_pix;
	int          pix_base;
	int          exp_base;         // First expected word of the current run
	logic        run_active = 1'b0;
	int          beat_cnt;
	int          n_checks = 0;
	int          n_errors = 0;
	int          cycle_cnt = 0;
	int          max_cycles = 0;

	cnn_accel_top i_dut (
		.clk         (clk),
		.rstn        (rstn),
		.req_i       (req),
		.we_i        (we),
		.addr_i      (addr),
		.wdata_i     (wdata),
		.ack_o       (ack),
		.rdata_o     (rdata),
		.out_pixel_o (out_pixel),
		.out_valid_o (out_valid)
	);

	always #4 clk = ~clk;  // 8 ns period

	// --------------------------------------------------
	// Checking and reporting
	// --------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERROR %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic flag_failure(input string what);
		n_errors++;
		$display("FAILURE: %s at %0t", what, $time);
	endtask

	task automatic finish_run();
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	// --------------------------------------------------
	// Host port
	// --------------------------------------------------
	// One four-phase transfer, then a short random idle gap
	task automatic bus_access(input logic wr, input logic [REG_AW-1:0] a,
	                          input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] q);
		int gap;
		@(negedge clk);
		check_value("ack_o before req_i", {31'b0, ack}, 32'h0);
		req   = 1'b1;
		we    = wr;
		addr  = a;
		wdata = d;
		do @(negedge clk); while (!ack);
		q   = rdata;  // Valid while ack is high
		req = 1'b0;
		do @(negedge clk); while (ack);
		we    = 1'b0;
		wdata = '0;
		gap   = $urandom_range(3, 0);
		repeat (gap) begin
			@(negedge clk);
			check_value("ack_o while idle", {31'b0, ack}, 32'h0);
		end
	endtask

	task automatic reg_write(input logic [REG_AW-1:0] a, input logic [DATA_W-1:0] d);
		logic [DATA_W-1:0] discard;
		bus_access(1'b1, a, d, discard);
	endtask

	task automatic reg_read(input logic [REG_AW-1:0] a, output logic [DATA_W-1:0] q);
		bus_access(1'b0, a, '0, q);
	endtask

	task automatic write_and_verify(input string name, input logic [REG_AW-1:0] a,
	                                input logic [DATA_W-1:0] d);
		logic [DATA_W-1:0] q;
		reg_write(a, d);
		reg_read(a, q);
		check_value(name, q, d);
	endtask

	// --------------------------------------------------
	// Output stream
	// --------------------------------------------------
	always @(negedge clk) begin
		if (rstn && out_valid) begin
			if (!run_active) begin
				flag_failure("out_valid_o pulsed with no layer running");
			end else begin
				if (beat_cnt < n_pix) begin
					check_value($sformatf("out_pixel_o beat %0d", beat_cnt), out_pixel,
					            tdata[exp_base + beat_cnt]);
				end
				beat_cnt++;
			end
		end
	end

	// Starts one layer and follows it to the end of its stream
	task automatic run_layer(input int base);
		logic [DATA_W-1:0] q;
		beat_cnt   = 0;
		exp_base   = base;
		run_active = 1'b1;
		reg_write(REG_START, 32'h1);
		reg_read(REG_DONE, q);
		check_value("DONE after START", q, 32'h0);
		while (beat_cnt < n_pix) @(negedge clk);  // Watchdog ends a stalled run
		reg_read(REG_DONE, q);
		check_value("DONE after last beat", q, 32'h1);
		repeat (2 * N_TAPS) @(negedge clk);       // Room for a stray beat
		check_value("out_valid_o beat count", beat_cnt, n_pix);
		run_active = 1'b0;
	endtask

	task automatic run_tests();
		logic [DATA_W-1:0] q;
		repeat (16) @(negedge clk);
		rstn = 1'b1;
		repeat (2) @(negedge clk);

		// Register readback
		reg_read(REG_DONE, q);
		check_value("DONE after reset", q, 32'h0);
		write_and_verify("DIM", REG_DIM, tdata[0]);
		write_and_verify("LAYER_CFG relu", REG_LAYER_CFG, tdata[1]);
		for (int k = 0; k < N_KERN; k++) begin
			reg_write(REG_BIAS_BASE + REG_AW'(k), tdata[3 + k]);
		end
		for (int k = 0; k < N_KERN; k++) begin
			reg_read(REG_BIAS_BASE + REG_AW'(k), q);
			check_value($sformatf("BIAS %0d", k), q, tdata[3 + k]);
		end
		for (int t = 0; t < N_TAPS; t++) begin
			write_and_verify($sformatf("WEIGHT %0d", t), REG_WEIGHT_BASE + REG_AW'(t),
			                 tdata[7 + t]);
		end

		// Image load through the auto-incrementing index
		reg_write(REG_IMG_INDEX, 32'h0);
		for (int i = 0; i < n_pix; i++) begin
			reg_write(REG_IMG_DATA, tdata[pix_base + i]);
		end
		reg_read(REG_IMG_INDEX, q);
		check_value("IMG_INDEX after load", q, n_pix);

		run_layer(pix_base + n_pix);

		// Same image, linear output
		write_and_verify("LAYER_CFG linear", REG_LAYER_CFG, tdata[2]);
		run_layer(pix_base + 2 * n_pix);
	endtask

	// --------------------------------------------------
	// Watchdog
	// --------------------------------------------------
	always @(posedge clk) begin
		cycle_cnt++;
		if (max_cycles > 0 && cycle_cnt > max_cycles) begin
			flag_failure($sformatf("timeout, the run did not end within %0d cycles",
			                       max_cycles));
			finish_run();
		end
	end

	initial begin
		int width;
		int height;
		rstn  = 1'b0;
		req   = 1'b0;
		we    = 1'b0;
		addr  = '0;
		wdata = '0;
		void'($urandom(32'h6ec));
		$readmemh("tests/cnn_testdata.hex", tdata);
		width    = int'(tdata[0][DIM_W-1:0]);
		height   = int'(tdata[0][16+DIM_W-1:16]);
		n_pix    = width * height;
		pix_base = 16;  // After DIM, two configs, four biases and nine weights
		if (width == 0 || height == 0 || pix_base + 3 * n_pix > 76) begin
			flag_failure("test data file is missing or does not fit the word layout");
		end else begin
			// Two layers plus 41 setup and check accesses and one per pixel
			max_cycles = 2 * (n_pix * N_TAPS + 50) + 60 * (41 + n_pix) + 500;
			run_tests();
		end
		finish_run();
	end

endmodule

`default_nettype wire
